// ==== tb.f ====
+incdir+hdl
hdl/fetch_pkg.sv
hdl/InstructionDecoder.sv
hdl/FetchUnit.sv
hdl/ImemArbiter.sv
hdl/InstrMem.sv
hdl/DualFetchTop.sv
sim/fetch_asserts.sv
sim/tb_DualFetchTop.sv

// ==== Makefile ====
VERILATOR = verilator
VFLAGS    = --binary --timing --assert
TOP       = tb_DualFetchTop
FILELIST  = tb.f
OBJDIR    = obj_dir
BIN       = $(OBJDIR)/V$(TOP)
LOG       = sim.log
SOURCES   = $(shell grep -v '^+' $(FILELIST)) $(wildcard hdl/*.svh)

.PHONY: all run clean

all: run

# Rebuilt only when a source or the file list changes
$(BIN): $(SOURCES) $(FILELIST)
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(OBJDIR)

run: $(BIN)
	./$(BIN) | tee $(LOG)
	grep -q -F '*** PASSED ***' $(LOG)

clean:
	rm -rf $(OBJDIR) $(LOG)

// ==== sim/tb_DualFetchTop.sv ====
`timescale 1ns/1ps
`default_nettype none
`include "fetch_config.svh"

module tb_DualFetchTop;

  import fetch_pkg::*;

  localparam int ProgWords     = 41;             // 40 random words plus HLT
  localparam int RegionWords   = ProgWords + 8;  // Tail covers prefetch past HLT
  localparam int HltIndex      = 40;
  localparam int TimeoutCycles = 2 * RegionWords * 100 * 4;
  localparam instrT HltWord    = 16'hE800;
  localparam logic [39:0] OpcodeList = 40'hDC98765320;  // Nibble i is opcode choice i

  typedef struct packed {
    pcT      pc;
    instrIdT id;
    regIdxT  regD;
    regIdxT  regA;
    regIdxT  regB;
    condT    cond;
    offsetT  offset;
  } recT;

  logic    clk, rstN, start, loadEn, credit0, credit1;
  pcT      loadAddr, pc0, pc1;
  instrT   loadData;
  logic    outValid0, outValid1, halted0, halted1;
  instrIdT id0, id1;
  regIdxT  regD0, regA0, regB0, regD1, regA1, regB1;
  condT    cond0, cond1;
  offsetT  offset0, offset1;

  instrT image [`FETCH_IMEM_DEPTH];
  recT   expQ0 [$];  // Thread 0 records still to come
  recT   expQ1 [$];
  int    received [2]    = '{0, 0};
  int    returned [2]    = '{0, 0};
  int    creditsSeen [2] = '{0, 0};
  bit    doneRec [2]     = '{1'b0, 1'b0};
  int    errs [6]        = '{0, 0, 0, 0, 0, 0};
  string behName [6]     = '{"decode fields", "pc order", "credit bound",
                             "halt", "completion", "idle before start"};

  DualFetchTop i_DualFetchTop (
    .clk (clk), .rstN (rstN), .start (start), .loadEn (loadEn),
    .loadAddr (loadAddr), .loadData (loadData), .credit0 (credit0), .credit1 (credit1),
    .outValid0 (outValid0), .id0 (id0), .regD0 (regD0), .regA0 (regA0), .regB0 (regB0),
    .cond0 (cond0), .offset0 (offset0), .pc0 (pc0), .halted0 (halted0),
    .outValid1 (outValid1), .id1 (id1), .regD1 (regD1), .regA1 (regA1), .regB1 (regB1),
    .cond1 (cond1), .offset1 (offset1), .pc1 (pc1), .halted1 (halted1)
  );

  function automatic int baseOf(input int t);
    return (t == 0) ? int'(`FETCH_BASE0) : int'(`FETCH_BASE1);
  endfunction

  function automatic instrT randomWord();
    int          pick;
    logic [31:0] r;
    instrT       w;
    pick = $urandom % 13;
    r    = $urandom;
    if (pick < 10) begin
      w = {OpcodeList[pick*4 +: 4], r[11:0]};
    end else if (pick == 10) begin
      w = {4'hE, 1'b0, r[10:0]};  // NOP, bit 11 clear
    end else if (pick == 11) begin
      w = 16'hFFFF;
    end else begin
      w = 16'hF000;
    end
    return w;
  endfunction

  // Expected decode of one word, pc left at zero
  function automatic recT modelDecode(input instrT w);
    recT        r;
    logic [3:0] opc;
    opc    = w[15:12];
    r      = '0;
    r.cond = 4'hF;
    case (opc)
      4'd0, 4'd6, 4'd7, 4'd8: begin
        if (opc == 4'd0) r.id = 7'd1 + {6'd0, w[11]};
        else r.id = ((opc == 4'd6) ? 7'd48 : (opc == 4'd7) ? 7'd50 : 7'd52) + {6'd0, w[11]};
        r.regD   = {1'b0, w[2:0]};
        r.regA   = {1'b0, w[5:3]};
        r.offset = {3'b000, w[10:6]};
      end
      4'd2, 4'd3: begin
        r.id     = ((opc == 4'd2) ? 7'd8 : 7'd10) + {6'd0, w[11]};
        r.regD   = {1'b0, w[10:8]};
        r.regA   = {1'b0, w[10:8]};
        r.offset = w[7:0];
      end
      4'd5: begin
        r.id   = 7'd40 + {4'd0, w[11:9]};
        r.regD = {1'b0, w[2:0]};
        r.regA = {1'b0, w[5:3]};
        r.regB = {1'b0, w[8:6]};
      end
      4'd9: begin
        r.id     = 7'd54 + {6'd0, w[11]};
        r.regD   = {1'b0, w[10:8]};
        r.regA   = 4'd14;
        r.offset = w[7:0];
      end
      4'd12: begin
        r.id     = ID_SWI;
        r.offset = 8'd9;
        r.regB   = 4'd13;
        r.cond   = 4'd14;
      end
      4'd13: begin
        r.id     = 7'd73;
        r.cond   = w[11:8];
        r.regA   = 4'd15;
        r.offset = w[7:0];
      end
      4'd14: r.id = w[11] ? ID_HLT : ID_NOP;
      default: r.id = (w == 16'hFFFF) ? ID_RESET : ID_UNDEF;
    endcase
    return r;
  endfunction

  task automatic checkField(input int beh, input int t, input string name,
                            input int expV, input int gotV);
    assert (gotV == expV) else begin
      $display("FAIL %0t: %s%0d expected %0h got %0h", $time, name, t, expV, gotV);
      errs[beh]++;
    end
  endtask

  task automatic checkRecord(input int t, input recT got);
    recT exp;
    int  left;
    left = (t == 0) ? expQ0.size() : expQ1.size();
    received[t]++;
    assert (received[t] <= creditsSeen[t] + `FETCH_CREDITS) else begin
      $display("Thread %0d presented more records than its credits allow at %0t", t, $time);
      errs[2]++;
    end
    assert (left > 0) else begin
      $display("Thread %0d presented an extra record at pc %0h after HLT", t, got.pc);
      errs[3]++;
    end
    if (left > 0) begin
      if (t == 0) exp = expQ0.pop_front();
      else exp = expQ1.pop_front();
      checkField(1, t, "pc", int'(exp.pc), int'(got.pc));
      checkField(0, t, "id", int'(exp.id), int'(got.id));
      checkField(0, t, "regD", int'(exp.regD), int'(got.regD));
      checkField(0, t, "regA", int'(exp.regA), int'(got.regA));
      checkField(0, t, "regB", int'(exp.regB), int'(got.regB));
      checkField(0, t, "cond", int'(exp.cond), int'(got.cond));
      checkField(0, t, "offset", int'(exp.offset), int'(got.offset));
      if (exp.id == ID_HLT) doneRec[t] = 1'b1;
    end
  endtask

  initial begin
    clk = 1'b0;
    forever #10 clk = ~clk;
  end

  initial begin
    repeat (TimeoutCycles) @(posedge clk);
    $display("Timeout: threads did not both halt within %0d cycles", TimeoutCycles);
    $display("*** FAILED ***");
    $finish;
  end

  // Consumer returns owed credits at random
  initial begin
    credit0 <= 1'b0;
    credit1 <= 1'b0;
    forever begin
      @(posedge clk);
      credit0 <= 1'b0;
      credit1 <= 1'b0;
      if (received[0] > returned[0] && ($urandom % 2) == 1) begin
        credit0 <= 1'b1;
        returned[0]++;
      end
      if (received[1] > returned[1] && ($urandom % 2) == 1) begin
        credit1 <= 1'b1;
        returned[1]++;
      end
    end
  end

  always @(negedge clk) begin
    if (!start) begin
      assert (!(outValid0 || outValid1 || halted0 || halted1)) else begin
        $display("Outputs became active before start at %0t", $time);
        errs[5]++;
      end
    end else begin
      if (outValid0) checkRecord(0, {pc0, id0, regD0, regA0, regB0, cond0, offset0});
      if (outValid1) checkRecord(1, {pc1, id1, regD1, regA1, regB1, cond1, offset1});
      checkField(3, 0, "halted", int'(doneRec[0]), int'(halted0));
      checkField(3, 1, "halted", int'(doneRec[1]), int'(halted1));
      if (credit0) creditsSeen[0]++;  // Counted after the bound check
      if (credit1) creditsSeen[1]++;
    end
  end

  initial begin
    pcT    a;
    instrT w;
    recT   rec;
    int    total;
    int    failing;
    rstN     <= 1'b0;
    start    <= 1'b0;
    loadEn   <= 1'b0;
    loadAddr <= '0;
    loadData <= '0;
    void'($urandom(27));
    for (int t = 0; t < 2; t++) begin
      for (int k = 0; k < RegionWords; k++) begin
        a        = pcT'(baseOf(t) + k);
        w        = (k == HltIndex) ? HltWord : randomWord();
        image[a] = w;
        rec      = modelDecode(w);
        rec.pc   = a;
        if (k <= HltIndex && t == 0) expQ0.push_back(rec);
        if (k <= HltIndex && t == 1) expQ1.push_back(rec);
      end
    end
    repeat (5) @(posedge clk);
    rstN <= 1'b1;
    for (int t = 0; t < 2; t++) begin
      for (int k = 0; k < RegionWords; k++) begin
        a = pcT'(baseOf(t) + k);
        @(posedge clk);
        loadEn   <= 1'b1;
        loadAddr <= a;
        loadData <= image[a];
      end
    end
    @(posedge clk);
    loadEn <= 1'b0;
    $display("Behavior 6 %s: %0d errors", behName[5], errs[5]);
    start <= 1'b1;
    wait (halted0 && halted1);
    repeat (4 * `FETCH_CREDITS) @(posedge clk);  // Late responses must stay hidden
    for (int t = 0; t < 2; t++) begin
      checkField(4, t, "recordCount", ProgWords, received[t]);
    end
    total   = 0;
    failing = 0;
    for (int b = 0; b < 6; b++) begin
      if (b < 5) $display("Behavior %0d %s: %0d errors", b + 1, behName[b], errs[b]);
      total += errs[b];
      if (errs[b] != 0) failing++;
    end
    $display("Summary: 6 behaviors, %0d failing, %0d errors", failing, total);
    if (total == 0) begin
      $display("*** PASSED ***");
    end else begin
      $display("*** FAILED ***");
    end
    $finish;
  end

endmodule

`default_nettype wire

// ==== sim/fetch_asserts.sv ====
`timescale 1ns/1ps
`default_nettype none
`include "fetch_config.svh"

module FetchAsserts #(
  parameter int CreditW  = 3,
  parameter bit TwoPorts = 1'b1  // Both requesters visible, as at the arbiter
) (
  input logic               clk,
  input logic               rstN,
  input logic               reqA,
  input logic               reqB,
  input logic               gntA,
  input logic               gntB,
  input logic               rspA,
  input logic               rspB,
  input logic [CreditW-1:0] credits
);

  gntNeedsReqA: assert property (@(posedge clk) disable iff (!rstN) gntA |-> reqA)
    else $error("Grant A without request A");

  rspAfterGntA: assert property (@(posedge clk) disable iff (!rstN) gntA |=> rspA)
    else $error("Response A missing one cycle after grant");
  rspFromGntA: assert property (@(posedge clk) disable iff (!rstN) rspA |-> $past(gntA))
    else $error("Response A without a grant one cycle earlier");

  if (TwoPorts) begin : gPortB
    // One reader of the shared memory per cycle
    gntExclusive: assert property (@(posedge clk) disable iff (!rstN) !(gntA && gntB))
      else $error("Both grants high in the same cycle");

    gntNeedsReqB: assert property (@(posedge clk) disable iff (!rstN) gntB |-> reqB)
      else $error("Grant B without request B");

    rspAfterGntB: assert property (@(posedge clk) disable iff (!rstN) gntB |=> rspB)
      else $error("Response B missing one cycle after grant");
    rspFromGntB: assert property (@(posedge clk) disable iff (!rstN) rspB |-> $past(gntB))
      else $error("Response B without a grant one cycle earlier");
  end else begin : gCredits
    creditBound: assert property (@(posedge clk) disable iff (!rstN)
                                  int'(credits) <= `FETCH_CREDITS)
      else $error("Free credits above the reset count");
  end

endmodule

bind ImemArbiter FetchAsserts #(.CreditW(1), .TwoPorts(1'b1)) i_arbAsserts (
  .clk (clk), .rstN (rstN), .reqA (req0), .reqB (req1), .gntA (gnt0), .gntB (gnt1),
  .rspA (rspValid0), .rspB (rspValid1), .credits (1'b0)
);

bind FetchUnit FetchAsserts #(.CreditW($clog2(`FETCH_CREDITS + 1)), .TwoPorts(1'b0))
  i_unitAsserts (
  .clk (clk), .rstN (rstN), .reqA (req), .reqB (1'b0), .gntA (gnt), .gntB (1'b0),
  .rspA (rspValid), .rspB (1'b0), .credits (freeCredits)
);

`default_nettype wire

// ==== hdl/DualFetchTop.sv ====
`timescale 1ns/1ps
`default_nettype none
`include "fetch_config.svh"

module DualFetchTop (
  input  logic               clk,
  input  logic               rstN,
  input  logic               start,
  input  logic               loadEn,
  input  fetch_pkg::pcT      loadAddr,
  input  fetch_pkg::instrT   loadData,
  input  logic               credit0,
  input  logic               credit1,
  output logic               outValid0,
  output fetch_pkg::instrIdT id0,
  output fetch_pkg::regIdxT  regD0,
  output fetch_pkg::regIdxT  regA0,
  output fetch_pkg::regIdxT  regB0,
  output fetch_pkg::condT    cond0,
  output fetch_pkg::offsetT  offset0,
  output fetch_pkg::pcT      pc0,
  output logic               halted0,
  output logic               outValid1,
  output fetch_pkg::instrIdT id1,
  output fetch_pkg::regIdxT  regD1,
  output fetch_pkg::regIdxT  regA1,
  output fetch_pkg::regIdxT  regB1,
  output fetch_pkg::condT    cond1,
  output fetch_pkg::offsetT  offset1,
  output fetch_pkg::pcT      pc1,
  output logic               halted1
);

  import fetch_pkg::*;

  logic  req0, req1, gnt0, gnt1;
  logic  rspValid0, rspValid1, memRe;
  pcT    reqAddr0, reqAddr1, memAddr;
  instrT memData, rspData;

  FetchUnit i_FetchUnit0 (
    .clk (clk), .rstN (rstN), .start (start), .basePc (`FETCH_BASE0),
    .req (req0), .reqAddr (reqAddr0), .gnt (gnt0),
    .rspValid (rspValid0), .rspData (rspData), .credit (credit0),
    .outValid (outValid0), .id (id0), .regD (regD0), .regA (regA0), .regB (regB0),
    .cond (cond0), .offset (offset0), .pc (pc0), .halted (halted0)
  );

  FetchUnit i_FetchUnit1 (
    .clk (clk), .rstN (rstN), .start (start), .basePc (`FETCH_BASE1),
    .req (req1), .reqAddr (reqAddr1), .gnt (gnt1),
    .rspValid (rspValid1), .rspData (rspData), .credit (credit1),
    .outValid (outValid1), .id (id1), .regD (regD1), .regA (regA1), .regB (regB1),
    .cond (cond1), .offset (offset1), .pc (pc1), .halted (halted1)
  );

  ImemArbiter i_ImemArbiter (
    .clk (clk), .rstN (rstN),
    .req0 (req0), .req1 (req1), .addr0 (reqAddr0), .addr1 (reqAddr1),
    .gnt0 (gnt0), .gnt1 (gnt1), .memAddr (memAddr), .memRe (memRe),
    .memData (memData), .rspValid0 (rspValid0), .rspValid1 (rspValid1),
    .rspData (rspData)
  );

  InstrMem i_InstrMem (
    .clk (clk), .re (memRe), .addr (memAddr), .rdata (memData),
    .we (loadEn), .waddr (loadAddr), .wdata (loadData)  // Loaded before start
  );

endmodule

`default_nettype wire

// ==== hdl/InstrMem.sv ====
`timescale 1ns/1ps
`default_nettype none
`include "fetch_config.svh"

module InstrMem (
  input  logic             clk,
  input  logic             re,
  input  fetch_pkg::pcT    addr,
  output fetch_pkg::instrT rdata,
  input  logic             we,
  input  fetch_pkg::pcT    waddr,
  input  fetch_pkg::instrT wdata
);

  import fetch_pkg::*;

  instrT mem [`FETCH_IMEM_DEPTH];

  always_ff @(posedge clk) begin
    if (we) begin
      mem[waddr] <= wdata;  // Loader port
    end
    if (re) begin
      rdata <= mem[addr];
    end
  end

endmodule

`default_nettype wire

// ==== hdl/ImemArbiter.sv ====
`timescale 1ns/1ps
`default_nettype none

module ImemArbiter (
  input  logic             clk,
  input  logic             rstN,
  input  logic             req0,
  input  logic             req1,
  input  fetch_pkg::pcT    addr0,
  input  fetch_pkg::pcT    addr1,
  output logic             gnt0,
  output logic             gnt1,
  output fetch_pkg::pcT    memAddr,
  output logic             memRe,
  input  fetch_pkg::instrT memData,
  output logic             rspValid0,
  output logic             rspValid1,
  output fetch_pkg::instrT rspData
);

  import fetch_pkg::*;

  logic lastWinner;  // 1 when unit 1 won the last grant
  logic rspPending;
  logic rspOwner;

  // Round robin, the unit not served last wins a tie
  assign gnt0    = req0 && (!req1 || lastWinner);
  assign gnt1    = req1 && (!req0 || !lastWinner);
  assign memRe   = gnt0 || gnt1;
  assign memAddr = gnt1 ? addr1 : addr0;

  assign rspValid0 = rspPending && !rspOwner;
  assign rspValid1 = rspPending && rspOwner;
  assign rspData   = memData;  // Read data lands one cycle after the grant

  always_ff @(posedge clk or negedge rstN) begin
    if (!rstN) begin
      lastWinner <= 1'b1;  // Unit 0 goes first
      rspPending <= 1'b0;
      rspOwner   <= 1'b0;
    end else begin
      rspPending <= memRe;
      if (memRe) begin
        lastWinner <= gnt1;
        rspOwner   <= gnt1;
      end
    end
  end

endmodule

`default_nettype wire

// ==== hdl/FetchUnit.sv ====
`timescale 1ns/1ps
`default_nettype none
`include "fetch_config.svh"

module FetchUnit (
  input  logic               clk,
  input  logic               rstN,
  input  logic               start,
  input  fetch_pkg::pcT      basePc,
  output logic               req,
  output fetch_pkg::pcT      reqAddr,
  input  logic               gnt,
  input  logic               rspValid,
  input  fetch_pkg::instrT   rspData,
  input  logic               credit,
  output logic               outValid,
  output fetch_pkg::instrIdT id,
  output fetch_pkg::regIdxT  regD,
  output fetch_pkg::regIdxT  regA,
  output fetch_pkg::regIdxT  regB,
  output fetch_pkg::condT    cond,
  output fetch_pkg::offsetT  offset,
  output fetch_pkg::pcT      pc,
  output logic               halted
);

  import fetch_pkg::*;

  localparam int QDepth  = `FETCH_CREDITS;
  localparam int QPtrW   = $clog2(QDepth);
  localparam int CreditW = $clog2(`FETCH_CREDITS + 1);

  logic               started;
  pcT                 fetchPc;
  pcT                 pcQueue [QDepth];  // Addresses of requests in flight
  logic [QPtrW-1:0]   wrPtr;
  logic [QPtrW-1:0]   rdPtr;
  logic [CreditW-1:0] freeCredits;
  logic               present;
  instrIdT            decId;
  regIdxT             decRegD;
  regIdxT             decRegA;
  regIdxT             decRegB;
  condT               decCond;
  offsetT             decOffset;

  assign req     = started && !halted && (freeCredits != '0);
  assign reqAddr = fetchPc;
  assign present = rspValid && !halted;  // Late responses after HLT are dropped

  InstructionDecoder i_InstructionDecoder (
    .instruction (rspData),
    .id          (decId),
    .regD        (decRegD),
    .regA        (decRegA),
    .regB        (decRegB),
    .cond        (decCond),
    .offset      (decOffset)
  );

  always_ff @(posedge clk or negedge rstN) begin
    if (!rstN) begin
      started     <= 1'b0;
      fetchPc     <= '0;
      wrPtr       <= '0;
      rdPtr       <= '0;
      freeCredits <= CreditW'(`FETCH_CREDITS);
      outValid    <= 1'b0;
      halted      <= 1'b0;
    end else begin
      if (start && !started) begin
        started <= 1'b1;
        fetchPc <= basePc;
      end else if (gnt) begin
        fetchPc <= pcT'((int'(fetchPc) + 1) % `FETCH_IMEM_DEPTH);
      end
      if (gnt) begin
        wrPtr <= (wrPtr == QPtrW'(QDepth - 1)) ? '0 : wrPtr + 1'b1;
      end
      if (rspValid) begin
        rdPtr <= (rdPtr == QPtrW'(QDepth - 1)) ? '0 : rdPtr + 1'b1;
      end
      // Reserve on grant, refill from consumer or from a dropped response
      freeCredits <= freeCredits - CreditW'(gnt) + CreditW'(credit)
                     + CreditW'(rspValid && halted);
      outValid    <= present;
      if (present && decId == ID_HLT) begin
        halted <= 1'b1;
      end
    end
  end

  always_ff @(posedge clk) begin
    if (gnt) begin
      pcQueue[wrPtr] <= fetchPc;
    end
    if (present) begin
      id     <= decId;
      regD   <= decRegD;
      regA   <= decRegA;
      regB   <= decRegB;
      cond   <= decCond;
      offset <= decOffset;
      pc     <= pcQueue[rdPtr];  // Tag with the address that was asked for
    end
  end

endmodule

`default_nettype wire

// ==== hdl/InstructionDecoder.sv ====
`timescale 1ns/1ps
`default_nettype none

module InstructionDecoder (
  input  fetch_pkg::instrT   instruction,
  output fetch_pkg::instrIdT id,
  output fetch_pkg::regIdxT  regD,    // Destination register
  output fetch_pkg::regIdxT  regA,    // Channel A
  output fetch_pkg::regIdxT  regB,    // Channel B
  output fetch_pkg::condT    cond,
  output fetch_pkg::offsetT  offset
);

  import fetch_pkg::*;

  logic [3:0] opcode;
  logic [3:0] funct2;
  logic [1:0] funct1;
  logic [2:0] aux;
  logic       op;

  always_comb begin
    opcode = instruction[15:12];
    op     = instruction[11];
    funct2 = instruction[11:8];
    funct1 = 2'd0;
    aux    = instruction[11:9];
    id     = '0;
    regD   = '0;
    regA   = '0;
    regB   = '0;
    cond   = 4'hF;  // No condition
    offset = '0;

    case (opcode)
      4'd0: begin  // Ids 1 and 2
        id     = op ? 7'h02 : 7'h01;
        offset = {3'b000, instruction[10:6]};
        regD   = {1'b0, instruction[2:0]};
        regA   = {1'b0, instruction[5:3]};
      end
      4'd1: begin  // Ids 3 to 7
        funct1 = instruction[10:9];
        regD   = {1'b0, instruction[2:0]};
        regA   = {1'b0, instruction[5:3]};
        if (!op) begin
          id     = 7'h03;
          offset = {3'b000, instruction[10:6]};
        end else if (funct1[1]) begin  // Three-bit immediate forms
          id     = funct1[0] ? 7'h07 : 7'h06;
          offset = {5'b00000, instruction[8:6]};
        end else begin
          id   = funct1[0] ? 7'h05 : 7'h04;
          regB = {1'b0, instruction[8:6]};
        end
      end
      4'd2, 4'd3: begin  // Ids 8 to 11
        id     = (opcode[0] ? 7'h0A : 7'h08) + {6'd0, op};
        offset = instruction[7:0];
        regD   = {1'b0, instruction[10:8]};
        regA   = {1'b0, instruction[10:8]};
      end
      4'd4: begin  // Ids 12 to 39
        funct1 = instruction[7:6];
        if (op) begin
          id     = 7'h27;
          offset = instruction[7:0];
          regD   = {1'b0, instruction[10:8]};
          regA   = 4'hF;
          regB   = {1'b0, instruction[10:8]};
        end else begin
          regD = {1'b0, instruction[2:0]};
          regA = {1'b0, instruction[2:0]};
          regB = {1'b0, instruction[5:3]};
          case (funct2)
            4'd0, 4'd1, 4'd2, 4'd3: id = 7'h0C + {3'd0, funct2[1:0], 2'b00} + {5'd0, funct1};
            4'd4: begin
              case (funct1)
                2'd1: begin
                  id      = 7'h1C;
                  regB[3] = 1'b1;
                end
                2'd2: begin
                  id      = 7'h1D;
                  regD[3] = 1'b1;
                  regA[3] = 1'b1;
                end
                2'd3: begin
                  id      = 7'h1E;
                  regD[3] = 1'b1;
                  regA[3] = 1'b1;
                  regB[3] = 1'b1;
                end
                default: id = 7'h0C;
              endcase
            end
            4'd5: begin
              case (funct1)
                2'd1: begin
                  id      = 7'h1F;
                  regB[3] = 1'b1;
                end
                2'd2, 2'd3: begin  // Same fields, ids 32 and 33
                  id      = funct1[0] ? 7'h21 : 7'h20;
                  regD[3] = 1'b1;
                  regA[3] = 1'b1;
                end
                default: id = 7'h0C;
              endcase
            end
            4'd6: begin  // Ids 34 to 37, high banks by funct1
              id      = 7'h22 + {5'd0, funct1};
              regD[3] = funct1[1];
              regA[3] = funct1[1];
              regB[3] = funct1[0];
            end
            4'd7: begin
              id   = 7'h26;
              cond = instruction[7:4];
              regD = '0;
              regA = 4'hF;
              regB = {1'b0, instruction[2:0]};
            end
            default: id = 7'h7D;
          endcase
        end
      end
      4'd5: begin  // Three-register ops, ids 40 to 47
        id   = 7'h28 + {4'd0, aux};
        regD = {1'b0, instruction[2:0]};
        regA = {1'b0, instruction[5:3]};
        regB = {1'b0, instruction[8:6]};
      end
      4'd6, 4'd7, 4'd8: begin  // Ids 48 to 53
        id     = 7'h30 + {2'd0, opcode - 4'd6, 1'b0} + {6'd0, op};
        regD   = {1'b0, instruction[2:0]};
        regA   = {1'b0, instruction[5:3]};
        offset = {3'b000, instruction[10:6]};
      end
      4'd9: begin
        id     = op ? 7'h37 : 7'h36;
        offset = instruction[7:0];
        regD   = {1'b0, instruction[10:8]};
        regA   = 4'hE;  // Link register
      end
      4'd10: begin
        id     = op ? 7'h39 : 7'h38;
        offset = instruction[7:0];
        regD   = {1'b0, instruction[10:8]};
        regA   = op ? 4'hE : 4'hF;
      end
      4'd11: begin  // Ids 58 to 71
        funct1 = instruction[7:6];
        case (funct2)
          4'd0:  id = 7'h3A;
          4'd2, 4'd10: begin
            id   = (funct2[3] ? 7'h3F : 7'h3B) + {5'd0, funct1};
            regD = {1'b0, instruction[2:0]};
            regB = {1'b0, instruction[5:3]};
          end
          4'd4, 4'd13: begin
            id   = funct2[0] ? 7'h44 : 7'h43;
            regD = {1'b0, instruction[2:0]};
          end
          4'd14: begin
            case (funct1)
              2'd0: begin  // OUTPUT
                id   = 7'h45;
                regD = {1'b0, instruction[2:0]};
              end
              2'd1: id = 7'h46;  // PAUSE
              2'd2: begin  // INPUT
                id   = 7'h47;
                regD = {1'b0, instruction[2:0]};
              end
              default: id = 7'h7A;
            endcase
          end
          default: id = 7'h7A;
        endcase
      end
      4'd12: begin
        id     = ID_SWI;
        offset = 8'd9;  // Trap vector
        regB   = 4'hD;
        cond   = 4'hE;  // Always taken
      end
      4'd13: begin  // Branch immediate
        id     = 7'h49;
        cond   = instruction[11:8];
        offset = instruction[7:0];
        regA   = 4'hF;  // pc
      end
      4'd14: id = op ? ID_HLT : ID_NOP;
      default: id = (instruction == 16'hFFFF) ? ID_RESET : ID_UNDEF;
    endcase
  end

endmodule

`default_nettype wire

// ==== hdl/fetch_pkg.sv ====
`default_nettype none

package fetch_pkg;

  typedef logic [15:0] instrT;    // One instruction word
  typedef logic [7:0]  pcT;       // Word address
  typedef logic [6:0]  instrIdT;  // Decoded instruction number
  typedef logic [3:0]  regIdxT;   // 14 is link, 15 is pc
  typedef logic [3:0]  condT;     // 15 none, 14 always
  typedef logic [7:0]  offsetT;   // Immediate field

  localparam instrIdT ID_SWI   = 7'h48;
  localparam instrIdT ID_NOP   = 7'h4A;
  localparam instrIdT ID_HLT   = 7'h4B;
  localparam instrIdT ID_RESET = 7'h64;  // All-ones word
  localparam instrIdT ID_UNDEF = 7'h7F;

endpackage

`default_nettype wire

// ==== hdl/fetch_config.svh ====
`ifndef FETCH_CONFIG_SVH
`define FETCH_CONFIG_SVH

// Instruction memory size in 16-bit words
`define FETCH_IMEM_DEPTH 256

// Credits each thread owns after reset
`define FETCH_CREDITS 4

// Thread start addresses
`define FETCH_BASE0 8'd0
`define FETCH_BASE1 8'd128

`endif
